//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

   localparam int inst_w      = 16;
   localparam int pc_w        = 8;                        // One word per address
   localparam int reg_n       = 8;
   localparam int reg_w       = $clog2(reg_n);
   localparam int busy_w      = 3;                        // Width of a busy counter
   localparam int queue_depth = 4;
   localparam int ptr_w       = $clog2(queue_depth);
   localparam int cnt_w       = $clog2(queue_depth + 1);

   // Top two bits of every instruction
   typedef enum logic [1:0] {
      op_ld     = 2'd0,
      op_st     = 2'd1,
      op_imm_br = 2'd2,
      op_alu    = 2'd3
   } major_op_e;

   typedef enum logic [2:0] {
      jk_none   = 3'd0,
      jk_always = 3'd1,
      jk_eq     = 3'd2,
      jk_lt     = 3'd3,
      jk_le     = 3'd4,
      jk_ne     = 3'd5
   } jump_kind_e;

   // Same encoding as the ty field of ALU instructions
   typedef enum logic [3:0] {
      alu_add  = 4'd0,
      alu_sub  = 4'd1,
      alu_and  = 4'd2,
      alu_or   = 4'd3,
      alu_xor  = 4'd4,
      alu_cmp  = 4'd5,
      alu_mov  = 4'd6,
      alu_rsv  = 4'd7,
      alu_sll  = 4'd8,
      alu_slr  = 4'd9,
      alu_srl  = 4'd10,
      alu_sra  = 4'd11,
      alu_in   = 4'd12,
      alu_out  = 4'd13,
      alu_ext  = 4'd14,
      alu_nop  = 4'd15
   } alu_op_e;

endpackage

`default_nettype wire

//--- controller.sv
`timescale 1ns/1ps
`default_nettype none

module controller import cpu_pkg::*; (
   input  logic              flushed,
   input  logic [inst_w-1:0] inst_id,
   output jump_kind_e        jump_inst,
   output logic              is_halt_id,
   output logic              main_mem_read_id,
   output logic              main_mem_write_id,
   output logic              from_main_mem_id,
   output logic              lock_en_id,
   output logic              unlock_en_id,
   output logic              regwrite_id,
   output logic              regwrite_adr_controll,
   output logic              out_en_id,
   output logic [1:0]        ALUsrcA_controll_id,
   output logic [1:0]        ALUsrcB_controll_id,
   output alu_op_e           ALUop_id,
   output logic [1:0]        regwrite_dat_controll_id,
   output logic [3:0]        d_id,
   output logic              use_ra,
   output logic              use_rb,
   output logic [reg_w-1:0]  ra,
   output logic [reg_w-1:0]  rb
);

   major_op_e  op;
   logic [3:0] ty;

   assign op   = major_op_e'(inst_id[15:14]);
   assign ra   = inst_id[13:11];
   assign rb   = inst_id[10:8];
   assign ty   = inst_id[7:4];
   assign d_id = inst_id[3:0];

   always_comb begin
      jump_inst                = jk_none;
      is_halt_id               = 1'b0;
      main_mem_read_id         = 1'b0;
      main_mem_write_id        = 1'b0;
      from_main_mem_id         = 1'b0;
      lock_en_id               = 1'b0;
      unlock_en_id             = 1'b0;
      regwrite_id              = 1'b0;
      regwrite_adr_controll    = 1'b0;
      out_en_id                = 1'b0;
      ALUsrcA_controll_id      = 2'd0;
      ALUsrcB_controll_id      = 2'd0;
      ALUop_id                 = alu_nop;
      regwrite_dat_controll_id = 2'd0;
      use_ra                   = 1'b0;
      use_rb                   = 1'b0;

      if (!flushed) begin
         case (op)
            op_ld: begin
               use_rb                = 1'b1;
               regwrite_id           = 1'b1;
               regwrite_adr_controll = 1'b1;               // Destination is rb
               ALUsrcB_controll_id   = 2'd2;
               from_main_mem_id      = 1'b1;
               main_mem_read_id      = 1'b1;
            end
            op_st: begin
               use_ra              = 1'b1;
               use_rb              = 1'b1;
               main_mem_write_id   = 1'b1;
               ALUsrcB_controll_id = 2'd2;
            end
            op_imm_br: begin
               case (ra)                                   // ra selects the sub-op here
                  3'd0: begin                              // LI
                     regwrite_id              = 1'b1;
                     regwrite_dat_controll_id = 2'd3;
                  end
                  3'd1: begin                              // ADDI
                     use_rb              = 1'b1;
                     regwrite_id         = 1'b1;
                     ALUop_id            = alu_add;
                     ALUsrcB_controll_id = 2'd2;
                  end
                  3'd2: begin                              // CMPI
                     use_rb              = 1'b1;
                     ALUop_id            = alu_cmp;
                     ALUsrcB_controll_id = 2'd2;
                  end
                  3'd3: begin
                     unlock_en_id = inst_id[0];
                     lock_en_id   = ~inst_id[0];
                  end
                  3'd4: begin                              // B
                     jump_inst           = jk_always;
                     ALUsrcA_controll_id = 2'd1;
                     ALUsrcB_controll_id = 2'd2;
                  end
                  3'd5: begin                              // BAL
                     jump_inst                = jk_always;
                     ALUsrcA_controll_id      = 2'd1;
                     ALUsrcB_controll_id      = 2'd2;
                     regwrite_id              = 1'b1;
                     regwrite_dat_controll_id = 2'd2;
                  end
                  3'd6: begin                              // BR
                     jump_inst           = jk_always;
                     ALUsrcB_controll_id = 2'd2;
                  end
                  default: begin                           // Conditional branches
                     ALUsrcA_controll_id = 2'd1;
                     ALUsrcB_controll_id = 2'd2;
                     case (rb)
                        3'd0:    jump_inst = jk_eq;
                        3'd1:    jump_inst = jk_lt;
                        3'd2:    jump_inst = jk_le;
                        3'd3:    jump_inst = jk_ne;
                        default: jump_inst = jk_always;
                     endcase
                  end
               endcase
            end
            op_alu: begin
               ALUop_id = alu_op_e'(ty);
               case (ty)
                  4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin
                     use_ra      = 1'b1;
                     use_rb      = 1'b1;
                     regwrite_id = 1'b1;
                  end
                  4'd5: begin                              // CMP
                     use_ra = 1'b1;
                     use_rb = 1'b1;
                  end
                  4'd6: begin                              // MOV
                     use_ra              = 1'b1;
                     ALUsrcA_controll_id = 2'd2;
                     regwrite_id         = 1'b1;
                  end
                  4'd8, 4'd9, 4'd10, 4'd11: begin          // Shifts
                     use_rb      = 1'b1;
                     regwrite_id = 1'b1;
                     if (d_id == 4'd0) begin
                        use_ra = 1'b1;                     // Amount from ra
                     end else begin
                        ALUsrcB_controll_id = 2'd1;
                     end
                  end
                  4'd12: begin                             // IN
                     regwrite_id         = 1'b1;
                     ALUsrcA_controll_id = 2'd2;
                     ALUsrcB_controll_id = 2'd3;
                  end
                  4'd13: begin                             // OUT
                     use_ra    = 1'b1;
                     use_rb    = 1'b1;
                     out_en_id = 1'b1;
                  end
                  4'd15: is_halt_id = 1'b1;
                  default: ;
               endcase
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- inst_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module inst_fetch import cpu_pkg::*; (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              redirect,
   input  logic [pc_w-1:0]   redirect_pc,
   output logic              imem_req,
   output logic [pc_w-1:0]   imem_addr,
   input  logic [inst_w-1:0] imem_data,
   input  logic [cnt_w-1:0]  count,
   output logic              push,
   output logic [inst_w-1:0] push_inst,
   output logic [pc_w-1:0]   push_pc
);

   logic [pc_w-1:0] pc;
   logic [pc_w-1:0] pend_pc;
   logic            pend;                                 // Word due from memory this cycle
   logic            started;
   logic            credit;

   // Queue slots not yet claimed by a word in flight
   assign credit = (count + cnt_w'(pend)) < cnt_w'(queue_depth);

   assign imem_req  = started & credit & ~redirect;
   assign imem_addr = pc;

   assign push      = pend & ~redirect;                   // Redirect kills the returning word
   assign push_inst = imem_data;
   assign push_pc   = pend_pc;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc      <= '0;
         pend    <= 1'b0;
         started <= 1'b0;
      end else begin
         started <= 1'b1;
         pend    <= imem_req;
         if (redirect) begin
            pc <= redirect_pc;
         end else if (imem_req) begin
            pc <= pc + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (imem_req) begin
         pend_pc <= pc;
      end
   end

endmodule

`default_nettype wire

//--- inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

module inst_queue import cpu_pkg::*; (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              flush,
   input  logic              push,
   input  logic [inst_w-1:0] push_inst,
   input  logic [pc_w-1:0]   push_pc,
   input  logic              pop,
   output logic              empty,
   output logic [cnt_w-1:0]  count,
   output logic [inst_w-1:0] head_inst,
   output logic [pc_w-1:0]   head_pc
);

   logic [inst_w-1:0] inst_mem [queue_depth];
   logic [pc_w-1:0]   pc_mem   [queue_depth];
   logic [ptr_w-1:0]  wr_ptr;
   logic [ptr_w-1:0]  rd_ptr;
   logic              do_push;
   logic              do_pop;

   assign do_push = push & ~flush;                        // Push lost on a flush
   assign do_pop  = pop & ~flush & ~empty;

   assign empty     = (count == '0);
   assign head_inst = inst_mem[rd_ptr];
   assign head_pc   = pc_mem[rd_ptr];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;                      // Wraps at queue_depth
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         inst_mem[wr_ptr] <= push_inst;
         pc_mem[wr_ptr]   <= push_pc;
      end
   end

endmodule

`default_nettype wire

//--- decode_issue.sv
`timescale 1ns/1ps
`default_nettype none

module decode_issue import cpu_pkg::*; (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              redirect,
   input  logic              ex_stall,
   input  logic [busy_w-1:0] register_invalid [reg_n],
   input  logic              empty,
   input  logic [inst_w-1:0] head_inst,
   input  logic [pc_w-1:0]   head_pc,
   output logic              pop,
   output logic              halted,
   output logic              id_valid,
   output logic [pc_w-1:0]   id_pc,
   output jump_kind_e        jump_inst,
   output logic              is_halt_id,
   output logic              main_mem_read_id,
   output logic              main_mem_write_id,
   output logic              from_main_mem_id,
   output logic              lock_en_id,
   output logic              unlock_en_id,
   output logic              regwrite_id,
   output logic              regwrite_adr_controll,
   output logic              out_en_id,
   output logic [1:0]        ALUsrcA_controll_id,
   output logic [1:0]        ALUsrcB_controll_id,
   output alu_op_e           ALUop_id,
   output logic [1:0]        regwrite_dat_controll_id,
   output logic [3:0]        d_id,
   output logic [reg_w-1:0]  ra,
   output logic [reg_w-1:0]  rb
);

   jump_kind_e       dec_jump;
   alu_op_e          dec_aluop;
   logic             dec_halt;
   logic             dec_rd;
   logic             dec_wr;
   logic             dec_from_mem;
   logic             dec_lock;
   logic             dec_unlock;
   logic             dec_regwrite;
   logic             dec_adr;
   logic             dec_out_en;
   logic             dec_use_ra;
   logic             dec_use_rb;
   logic [1:0]       dec_srca;
   logic [1:0]       dec_srcb;
   logic [1:0]       dec_dat;
   logic [3:0]       dec_d;
   logic [reg_w-1:0] dec_ra;
   logic [reg_w-1:0] dec_rb;
   logic             hazard;

   controller u_controller (
      .flushed                  (redirect),
      .inst_id                  (head_inst),
      .jump_inst                (dec_jump),
      .is_halt_id               (dec_halt),
      .main_mem_read_id         (dec_rd),
      .main_mem_write_id        (dec_wr),
      .from_main_mem_id         (dec_from_mem),
      .lock_en_id               (dec_lock),
      .unlock_en_id             (dec_unlock),
      .regwrite_id              (dec_regwrite),
      .regwrite_adr_controll    (dec_adr),
      .out_en_id                (dec_out_en),
      .ALUsrcA_controll_id      (dec_srca),
      .ALUsrcB_controll_id      (dec_srcb),
      .ALUop_id                 (dec_aluop),
      .regwrite_dat_controll_id (dec_dat),
      .d_id                     (dec_d),
      .use_ra                   (dec_use_ra),
      .use_rb                   (dec_use_rb),
      .ra                       (dec_ra),
      .rb                       (dec_rb)
   );

   // Source register still being written somewhere down the pipe
   assign hazard = (dec_use_ra && register_invalid[dec_ra] != '0) ||
                   (dec_use_rb && register_invalid[dec_rb] != '0);

   assign pop = ~empty & ~hazard & ~ex_stall & ~redirect & ~halted;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         halted <= 1'b0;
      end else if (pop && dec_halt) begin
         halted <= 1'b1;                                  // Sticky until reset
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         id_valid          <= 1'b0;
         jump_inst         <= jk_none;
         is_halt_id        <= 1'b0;
         main_mem_read_id  <= 1'b0;
         main_mem_write_id <= 1'b0;
         from_main_mem_id  <= 1'b0;
         lock_en_id        <= 1'b0;
         unlock_en_id      <= 1'b0;
         regwrite_id       <= 1'b0;
         out_en_id         <= 1'b0;
         ALUop_id          <= alu_nop;
      end else if (redirect || (!ex_stall && !pop)) begin
         id_valid          <= 1'b0;                       // Bubble
         jump_inst         <= jk_none;
         is_halt_id        <= 1'b0;
         main_mem_read_id  <= 1'b0;
         main_mem_write_id <= 1'b0;
         from_main_mem_id  <= 1'b0;
         lock_en_id        <= 1'b0;
         unlock_en_id      <= 1'b0;
         regwrite_id       <= 1'b0;
         out_en_id         <= 1'b0;
         ALUop_id          <= alu_nop;
      end else if (pop) begin
         id_valid          <= 1'b1;
         jump_inst         <= dec_jump;
         is_halt_id        <= dec_halt;
         main_mem_read_id  <= dec_rd;
         main_mem_write_id <= dec_wr;
         from_main_mem_id  <= dec_from_mem;
         lock_en_id        <= dec_lock;
         unlock_en_id      <= dec_unlock;
         regwrite_id       <= dec_regwrite;
         out_en_id         <= dec_out_en;
         ALUop_id          <= dec_aluop;
      end
   end

   always_ff @(posedge clk) begin
      if (pop) begin
         id_pc                    <= head_pc;
         regwrite_adr_controll    <= dec_adr;
         ALUsrcA_controll_id      <= dec_srca;
         ALUsrcB_controll_id      <= dec_srcb;
         regwrite_dat_controll_id <= dec_dat;
         d_id                     <= dec_d;
         ra                       <= dec_ra;
         rb                       <= dec_rb;
      end
   end

endmodule

`default_nettype wire

//--- frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_top import cpu_pkg::*; (
   input  logic              clk,
   input  logic              arst_n,
   output logic              imem_req,
   output logic [pc_w-1:0]   imem_addr,
   input  logic [inst_w-1:0] imem_data,
   input  logic              redirect,
   input  logic [pc_w-1:0]   redirect_pc,
   input  logic [busy_w-1:0] register_invalid [reg_n],
   input  logic              ex_stall,
   output logic              id_valid,
   output logic [pc_w-1:0]   id_pc,
   output jump_kind_e        jump_inst,
   output logic              is_halt_id,
   output logic              main_mem_read_id,
   output logic              main_mem_write_id,
   output logic              from_main_mem_id,
   output logic              lock_en_id,
   output logic              unlock_en_id,
   output logic              regwrite_id,
   output logic              regwrite_adr_controll,
   output logic              out_en_id,
   output logic [1:0]        ALUsrcA_controll_id,
   output logic [1:0]        ALUsrcB_controll_id,
   output alu_op_e           ALUop_id,
   output logic [1:0]        regwrite_dat_controll_id,
   output logic [3:0]        d_id,
   output logic [reg_w-1:0]  ra,
   output logic [reg_w-1:0]  rb,
   output logic              halted
);

   logic              push, pop, empty;
   logic [inst_w-1:0] push_inst, head_inst;
   logic [pc_w-1:0]   push_pc, head_pc;
   logic [cnt_w-1:0]  count;

   inst_fetch u_fetch (
      .clk         (clk),
      .arst_n      (arst_n),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .imem_req    (imem_req),
      .imem_addr   (imem_addr),
      .imem_data   (imem_data),
      .count       (count),
      .push        (push),
      .push_inst   (push_inst),
      .push_pc     (push_pc)
   );

   inst_queue u_queue (
      .clk       (clk),
      .arst_n    (arst_n),
      .flush     (redirect),
      .push      (push),
      .push_inst (push_inst),
      .push_pc   (push_pc),
      .pop       (pop),
      .empty     (empty),
      .count     (count),
      .head_inst (head_inst),
      .head_pc   (head_pc)
   );

   decode_issue u_issue (
      .clk                      (clk),
      .arst_n                   (arst_n),
      .redirect                 (redirect),
      .ex_stall                 (ex_stall),
      .register_invalid         (register_invalid),
      .empty                    (empty),
      .head_inst                (head_inst),
      .head_pc                  (head_pc),
      .pop                      (pop),
      .halted                   (halted),
      .id_valid                 (id_valid),
      .id_pc                    (id_pc),
      .jump_inst                (jump_inst),
      .is_halt_id               (is_halt_id),
      .main_mem_read_id         (main_mem_read_id),
      .main_mem_write_id        (main_mem_write_id),
      .from_main_mem_id         (from_main_mem_id),
      .lock_en_id               (lock_en_id),
      .unlock_en_id             (unlock_en_id),
      .regwrite_id              (regwrite_id),
      .regwrite_adr_controll    (regwrite_adr_controll),
      .out_en_id                (out_en_id),
      .ALUsrcA_controll_id      (ALUsrcA_controll_id),
      .ALUsrcB_controll_id      (ALUsrcB_controll_id),
      .ALUop_id                 (ALUop_id),
      .regwrite_dat_controll_id (regwrite_dat_controll_id),
      .d_id                     (d_id),
      .ra                       (ra),
      .rb                       (rb)
   );

endmodule

`default_nettype wire

//--- frontend_sva.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_sva import cpu_pkg::*; (
   input logic              clk,
   input logic              arst_n,
   input logic              imem_req,
   input logic [pc_w-1:0]   imem_addr,
   input logic [inst_w-1:0] imem_data,
   input logic              redirect,
   input logic [pc_w-1:0]   redirect_pc,
   input logic [busy_w-1:0] register_invalid [reg_n],
   input logic              ex_stall,
   input logic              push,
   input logic              pop,
   input logic [cnt_w-1:0]  count,
   input logic              id_valid,
   input logic [pc_w-1:0]   id_pc,
   input jump_kind_e        jump_inst,
   input logic              is_halt_id,
   input logic              main_mem_read_id,
   input logic              main_mem_write_id,
   input logic              from_main_mem_id,
   input logic              lock_en_id,
   input logic              unlock_en_id,
   input logic              regwrite_id,
   input logic              regwrite_adr_controll,
   input logic              out_en_id,
   input logic [1:0]        ALUsrcA_controll_id,
   input logic [1:0]        ALUsrcB_controll_id,
   input alu_op_e           ALUop_id,
   input logic [1:0]        regwrite_dat_controll_id,
   input logic [3:0]        d_id,
   input logic [reg_w-1:0]  ra,
   input logic [reg_w-1:0]  rb,
   input logic              halted
);

   int                err_cnt = 0;
   logic [inst_w-1:0] seen [1 << pc_w];                   // Words as returned by memory
   logic [busy_w-1:0] busy_q [reg_n];
   logic              req_q;
   logic [pc_w-1:0]   addr_q;
   logic              stall_q;
   logic [pc_w-1:0]   expect_pc;
   logic              new_issue;
   logic [33:0]       exp_dec;
   logic [31:0]       act_bundle;
   logic              read_busy;

   // Returns {use_ra, use_rb, bundle} for one instruction word
   function automatic logic [33:0] decode_ref(input logic [inst_w-1:0] w);
      logic [1:0] op;
      logic [2:0] f_ra;
      logic [2:0] f_rb;
      logic [3:0] ty;
      logic [3:0] d;
      jump_kind_e jk;
      alu_op_e    alu;
      logic       ura, urb, halt, rd, wr, fm, lk, ulk, rw, adr, oe;
      logic [1:0] sa, sb, dat;
      op   = w[15:14];
      f_ra = w[13:11];
      f_rb = w[10:8];
      ty   = w[7:4];
      d    = w[3:0];
      {ura, urb, halt, rd, wr, fm, lk, ulk, rw, adr, oe} = '0;
      {sa, sb, dat} = '0;
      jk  = jk_none;
      alu = alu_nop;
      if (op == 2'd0) begin                               // Load
         {urb, rw, adr, fm, rd} = 5'b11111;
         sb = 2'd2;
      end else if (op == 2'd1) begin                      // Store
         {ura, urb, wr} = 3'b111;
         sb = 2'd2;
      end else if (op == 2'd2) begin
         rw  = (f_ra == 3'd0) || (f_ra == 3'd1) || (f_ra == 3'd5);
         urb = (f_ra == 3'd1) || (f_ra == 3'd2);
         sa  = (f_ra == 3'd4 || f_ra == 3'd5 || f_ra == 3'd7) ? 2'd1 : 2'd0;
         sb  = (f_ra == 3'd0 || f_ra == 3'd3) ? 2'd0 : 2'd2;
         dat = (f_ra == 3'd0) ? 2'd3 : (f_ra == 3'd5) ? 2'd2 : 2'd0;
         alu = (f_ra == 3'd1) ? alu_add : (f_ra == 3'd2) ? alu_cmp : alu_nop;
         ulk = (f_ra == 3'd3) && d[0];
         lk  = (f_ra == 3'd3) && !d[0];
         if (f_ra >= 3'd4 && f_ra <= 3'd6) begin
            jk = jk_always;
         end else if (f_ra == 3'd7) begin                 // Condition picked by rb
            case (f_rb)
               3'd0:    jk = jk_eq;
               3'd1:    jk = jk_lt;
               3'd2:    jk = jk_le;
               3'd3:    jk = jk_ne;
               default: jk = jk_always;
            endcase
         end
      end else begin                                      // Register ALU group
         alu  = alu_op_e'(ty);
         rw   = (ty <= 4'd4) || (ty == 4'd6) || (ty >= 4'd8 && ty <= 4'd12);
         urb  = (ty <= 4'd5) || (ty >= 4'd8 && ty <= 4'd11) || (ty == 4'd13);
         ura  = (ty <= 4'd6) || (ty == 4'd13) || (ty >= 4'd8 && ty <= 4'd11 && d == 4'd0);
         sa   = (ty == 4'd6 || ty == 4'd12) ? 2'd2 : 2'd0;
         sb   = (ty == 4'd12) ? 2'd3 : (ty >= 4'd8 && ty <= 4'd11 && d != 4'd0) ? 2'd1 : 2'd0;
         oe   = (ty == 4'd13);
         halt = (ty == 4'd15);
      end
      decode_ref = {ura, urb, jk, halt, rd, wr, fm, lk, ulk, rw, adr, oe,
                    sa, sb, alu, dat, d, f_ra, f_rb};
   endfunction

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         req_q     <= 1'b0;
         stall_q   <= 1'b0;
         expect_pc <= '0;
      end else begin
         req_q   <= imem_req;
         stall_q <= ex_stall;
         if (redirect) begin
            expect_pc <= redirect_pc;
         end else if (new_issue) begin
            expect_pc <= id_pc + 1'b1;                    // Wraps at the top of memory
         end
      end
   end

   always_ff @(posedge clk) begin
      addr_q <= imem_addr;
      busy_q <= register_invalid;
      if (req_q) begin
         seen[addr_q] <= imem_data;
      end
   end

   assign new_issue  = id_valid & ~stall_q;               // Fresh word, not a held one
   assign exp_dec    = decode_ref(seen[id_pc]);
   assign act_bundle = {jump_inst, is_halt_id, main_mem_read_id, main_mem_write_id,
                        from_main_mem_id, lock_en_id, unlock_en_id, regwrite_id,
                        regwrite_adr_controll, out_en_id, ALUsrcA_controll_id,
                        ALUsrcB_controll_id, ALUop_id, regwrite_dat_controll_id,
                        d_id, ra, rb};
   assign read_busy  = (exp_dec[33] && busy_q[ra] != '0) || (exp_dec[32] && busy_q[rb] != '0);

   a_reset_quiet: assert property (@(posedge clk) !arst_n && $past(!arst_n) |->
         !imem_req && !push && !pop && !id_valid && !halted &&
         jump_inst == jk_none && ALUop_id == alu_nop && !regwrite_id &&
         !main_mem_read_id && !main_mem_write_id && !out_en_id)
      else begin
         $error("[ERROR] %0t: outputs not idle during reset", $time);
         err_cnt++;
      end

   a_reset_release: assert property (@(posedge clk) $rose(arst_n) |->
         !imem_req && !id_valid && !halted)
      else begin
         $error("[ERROR] %0t: outputs not idle just after reset", $time);
         err_cnt++;
      end

   a_decode: assert property (@(posedge clk) disable iff (!arst_n)
         id_valid |-> act_bundle == exp_dec[31:0])
      else begin
         $error("[ERROR] %0t: ID/EX bundle does not match the decode table", $time);
         err_cnt++;
      end

   a_hazard: assert property (@(posedge clk) disable iff (!arst_n)
         new_issue |-> !read_busy)
      else begin
         $error("[ERROR] %0t: issued while a source register was busy", $time);
         err_cnt++;
      end

   a_order: assert property (@(posedge clk) disable iff (!arst_n)
         new_issue |-> id_pc == expect_pc)
      else begin
         $error("[ERROR] %0t: issued PC out of program order", $time);
         err_cnt++;
      end

   a_redirect_bubble: assert property (@(posedge clk) disable iff (!arst_n)
         redirect |=> !id_valid)
      else begin
         $error("[ERROR] %0t: id_valid high after a redirect", $time);
         err_cnt++;
      end

   a_stall_valid: assert property (@(posedge clk) disable iff (!arst_n)
         ex_stall && !redirect |=> id_valid == $past(id_valid))
      else begin
         $error("[ERROR] %0t: id_valid changed under ex_stall", $time);
         err_cnt++;
      end

   a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
         ex_stall && !redirect && id_valid |=> $stable(id_pc) && $stable(act_bundle))
      else begin
         $error("[ERROR] %0t: ID/EX contents changed under ex_stall", $time);
         err_cnt++;
      end

   a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
         push |-> count < cnt_w'(queue_depth))
      else begin
         $error("[ERROR] %0t: push into a full queue", $time);
         err_cnt++;
      end

   a_req_push: assert property (@(posedge clk) disable iff (!arst_n)
         imem_req |=> push || redirect)
      else begin
         $error("[ERROR] %0t: request not pushed one cycle later", $time);
         err_cnt++;
      end

   a_halt_set: assert property (@(posedge clk) disable iff (!arst_n)
         id_valid && is_halt_id |-> halted)
      else begin
         $error("[ERROR] %0t: halt issued but halted low", $time);
         err_cnt++;
      end

   a_halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
         halted |=> halted)
      else begin
         $error("[ERROR] %0t: halted dropped before reset", $time);
         err_cnt++;
      end

   a_halt_quiet: assert property (@(posedge clk) disable iff (!arst_n)
         halted |=> !new_issue)
      else begin
         $error("[ERROR] %0t: instruction issued after halt", $time);
         err_cnt++;
      end

endmodule

bind frontend_top frontend_sva u_frontend_sva (.*);

`default_nettype wire

//--- tb_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_frontend import cpu_pkg::*; ();

   logic              clk;
   logic              arst_n;
   logic              imem_req;
   logic [pc_w-1:0]   imem_addr;
   logic [inst_w-1:0] imem_data;
   logic              redirect;
   logic [pc_w-1:0]   redirect_pc;
   logic [busy_w-1:0] register_invalid [reg_n];
   logic              ex_stall;
   logic              id_valid;
   logic [pc_w-1:0]   id_pc;
   jump_kind_e        jump_inst;
   logic              is_halt_id;
   logic              main_mem_read_id;
   logic              main_mem_write_id;
   logic              from_main_mem_id;
   logic              lock_en_id;
   logic              unlock_en_id;
   logic              regwrite_id;
   logic              regwrite_adr_controll;
   logic              out_en_id;
   logic [1:0]        ALUsrcA_controll_id;
   logic [1:0]        ALUsrcB_controll_id;
   alu_op_e           ALUop_id;
   logic [1:0]        regwrite_dat_controll_id;
   logic [3:0]        d_id;
   logic [reg_w-1:0]  ra;
   logic [reg_w-1:0]  rb;
   logic              halted;

   logic [inst_w-1:0] imem [1 << pc_w];

   frontend_top UUT (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Synchronous instruction memory, data one cycle after the request
   always @(posedge clk) begin
      if (imem_req) begin
         imem_data <= imem[imem_addr];
      end
   end

   task automatic stop_on_failure(input string why);
      $display("ERRORS FOUND");
      $fatal(1, "%s", why);
   endtask

   initial begin
      logic [31:0] w;
      int          gap;
      int          cycles;
      int          valid_cycles;
      int          cycle_limit;
      void'($urandom(19051));
      arst_n      = 1'b0;
      redirect    = 1'b0;
      redirect_pc = '0;
      ex_stall    = 1'b0;
      imem_data   = '0;
      foreach (register_invalid[i]) begin
         register_invalid[i] = '0;
      end
      for (int a = 0; a < (1 << pc_w); a++) begin
         w = $urandom;
         if (w[15:14] == 2'b11 && w[7:4] == 4'hf) begin
            w[7:4] = 4'he;                                // Halts only where planted
         end
         imem[a] = w[inst_w-1:0];
      end
      imem[8'hf9] = 16'hc0f0;                             // Halt words near the end
      imem[8'hfc] = 16'hc0f0;
      imem[8'hff] = 16'hc0f0;
      gap          = 40;
      cycles       = 0;
      valid_cycles = 0;
      cycle_limit  = 250 * 2 * 6;                         // Half rate, wide margin

      repeat (5) @(posedge clk);
      arst_n <= 1'b1;

      while (cycles < cycle_limit) begin
         @(posedge clk);
         cycles++;
         if (UUT.u_frontend_sva.err_cnt != 0) begin
            stop_on_failure("assertion failed in the frontend checker");
         end
         if (id_valid) begin
            valid_cycles++;
         end
         ex_stall <= ($urandom_range(4) == 0);
         foreach (register_invalid[i]) begin
            register_invalid[i] <= ($urandom_range(3) == 0) ? busy_w'($urandom_range(7, 1)) : '0;
         end
         gap--;
         if (gap == 0) begin
            redirect    <= 1'b1;
            redirect_pc <= pc_w'($urandom);
            gap = $urandom_range(60, 20);
         end else begin
            redirect <= 1'b0;
         end
      end

      if (UUT.u_frontend_sva.err_cnt != 0) begin
         stop_on_failure("assertion failed in the last cycle");
      end else if (valid_cycles == 0) begin
         stop_on_failure("no instruction ever reached the ID/EX register");
      end else begin
         $display("NO ERRORS");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- sim.f
cpu_pkg.sv
controller.sv
inst_fetch.sv
inst_queue.sv
decode_issue.sv
frontend_top.sv
frontend_sva.sv
tb_frontend.sv
